//--- Bender.yml
package:
  name: rom_loader

sources:
  - logic/loader_pkg.sv
  - logic/memmap_pkg.sv
  - logic/halfword_if.sv
  - logic/word_if.sv
  - logic/download_decoder.sv
  - logic/word_packer.sv
  - logic/mem_write_port.sv
  - logic/rom_loader.sv
  - target: simulation
    files:
      - sim/rom_loader_tb.sv

//--- logic/download_decoder.sv
//==========================================================
// Input stage of the ROM loader
// Decodes the download index into a target, raises the
// cart status flags and the copy start pulse, forwards
// boot ROM and handheld writes as halfwords and stalls the
// host while a handheld word is being written
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module download_decoder (
	input  wire logic                   clk_1x,
	input  wire logic                   RESET,
	input  wire logic                   ioctl_download,
	input  wire logic                   ioctl_wr,
	input  wire logic [7:0]             ioctl_index,
	input  wire loader_pkg::host_addr_t ioctl_addr,
	input  wire loader_pkg::halfword_t  ioctl_dout,
	output      logic                   ioctl_wait,
	output      logic                   cart_loaded,
	output      logic                   cart_main_download,
	output      logic                   cart_handheld_download,
	output      logic                   romcopy_start,
	output      loader_pkg::host_addr_t romcopy_size,
	halfword_if.src                     hw,
	input  wire logic                   done
);

	localparam int TGT_W = $bits(loader_pkg::dl_target_e);

	logic [loader_pkg::INDEX_SEL_W-1:0] index_sel;
	loader_pkg::dl_target_e             index_target;
	loader_pkg::dl_target_e             live_target;
	logic                               download_d;
	logic                               fwd_wr;

	assign index_sel = ioctl_index[loader_pkg::INDEX_SEL_W-1:0];

	// Indices above the enum range select nothing
	always_comb begin
		index_target = loader_pkg::NONE;
		if (index_sel[loader_pkg::INDEX_SEL_W-1:TGT_W] == '0)
			index_target = loader_pkg::dl_target_e'(index_sel[TGT_W-1:0]);
	end

	assign live_target = ioctl_download ? index_target : loader_pkg::NONE;
	assign fwd_wr = ioctl_wr &&
		(live_target == loader_pkg::BOOTROM || live_target == loader_pkg::CART_HANDHELD);

	//==========================================================
	// Status flags, copy start and host stall
	//==========================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			cart_main_download     <= 1'b0;
			cart_handheld_download <= 1'b0;
			cart_loaded            <= 1'b0;
			download_d             <= 1'b0;
			romcopy_start          <= 1'b0;
			ioctl_wait             <= 1'b0;
			hw.valid               <= 1'b0;
		end else begin
			cart_main_download     <= live_target == loader_pkg::CART_MAIN;
			cart_handheld_download <= live_target == loader_pkg::CART_HANDHELD;
			download_d             <= ioctl_download;
			hw.valid               <= fwd_wr;
			// Sticky once a main cart has been seen
			if (cart_main_download)
				cart_loaded <= 1'b1;
			romcopy_start <= !ioctl_download && download_d &&
				index_target == loader_pkg::CART_MAIN;
			// Hold the host until the RAM takes the word
			if (ioctl_wr && ioctl_addr[1] && live_target == loader_pkg::CART_HANDHELD)
				ioctl_wait <= 1'b1;
			else if (done)
				ioctl_wait <= 1'b0;
		end
	end

	// Final size is the address on the cycle the download drops
	always_ff @(posedge clk_1x) begin
		if (!ioctl_download && download_d)
			romcopy_size <= ioctl_addr;
		if (fwd_wr) begin
			hw.target <= live_target;
			hw.addr   <= ioctl_addr;
			hw.data   <= ioctl_dout;
			hw.bank   <= ioctl_index[6];
		end
	end

	// The host must respect the stall
	host_wait_a: assert property (@(posedge clk_1x) disable iff (!RESET)
		ioctl_wait |-> !ioctl_wr);

endmodule

`default_nettype wire

//--- logic/halfword_if.sv
//==========================================================
// Decoded halfwords from the download decoder to the packer
// No back-pressure, one halfword may arrive every cycle
//==========================================================
`timescale 1ns/1ns
`default_nettype none

interface halfword_if;

	logic                   valid;
	loader_pkg::dl_target_e target;
	loader_pkg::host_addr_t addr;
	loader_pkg::halfword_t  data;
	// Boot ROM bank, index bit 6
	logic                   bank;

	modport src (output valid, output target, output addr, output data, output bank);
	modport dst (input valid, input target, input addr, input data, input bank);

endinterface

`default_nettype wire

//--- logic/loader_pkg.sv
//==========================================================
// Host side types for the ROM download path
// Halfword, word and byte address as delivered by the host,
// plus the download targets selected by the download index
//==========================================================
`default_nettype none

package loader_pkg;

	// Low bits of the download index that select the target
	localparam int INDEX_SEL_W = 6;

	// One 16-bit unit from the host stream
	typedef logic [15:0] halfword_t;

	// Two halfwords packed for the memory side
	typedef logic [31:0] word_t;

	// Host byte address, 128 MiB range
	typedef logic [26:0] host_addr_t;

	// Encodings equal the download index values
	// Index 3 and anything above falls into NONE
	typedef enum logic [1:0] {
		BOOTROM       = 2'd0,
		CART_MAIN     = 2'd1,
		CART_HANDHELD = 2'd2,
		NONE          = 2'd3
	} dl_target_e;

endpackage

`default_nettype wire

//--- logic/mem_write_port.sv
//==========================================================
// Output stage of the ROM loader
// Boot ROM words turn into a registered one-cycle write;
// handheld words sit in an output register under
// valid/ready until the RAM takes them
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module mem_write_port (
	input  wire logic                  clk_1x,
	input  wire logic                  RESET,
	word_if.dst                        wd,
	output memmap_pkg::bootrom_addr_t  pifrom_wraddress,
	output loader_pkg::word_t          pifrom_wrdata,
	output logic                       pifrom_wren,
	output logic                       ram_wr_valid,
	output memmap_pkg::ram_addr_t      ram_wr_addr,
	output loader_pkg::word_t          ram_wr_data,
	input  wire logic                  ram_wr_ready
);

	logic rom_take;
	logic ram_take;
	logic ram_fire;

	// Boot ROM never stalls, RAM slot frees on the handshake
	assign wd.ready = wd.target == loader_pkg::BOOTROM || !ram_wr_valid || ram_wr_ready;
	assign rom_take = wd.valid && wd.target == loader_pkg::BOOTROM;
	assign ram_take = wd.valid && wd.ready && wd.target == loader_pkg::CART_HANDHELD;
	assign ram_fire = ram_wr_valid && ram_wr_ready;

	// Lets the decoder release the host
	assign wd.done = ram_fire;

	//==========================================================
	// Control
	//==========================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pifrom_wren  <= 1'b0;
			ram_wr_valid <= 1'b0;
		end else begin
			pifrom_wren <= rom_take;
			if (ram_take)
				ram_wr_valid <= 1'b1;
			else if (ram_fire)
				ram_wr_valid <= 1'b0;
		end
	end

	//==========================================================
	// Payload
	//==========================================================
	always_ff @(posedge clk_1x) begin
		if (rom_take) begin
			pifrom_wraddress <= wd.rom_addr;
			pifrom_wrdata    <= wd.data;
		end
		if (ram_take) begin
			ram_wr_addr <= wd.ram_addr;
			ram_wr_data <= wd.data;
		end
	end

	ram_hold_a: assert property (@(posedge clk_1x) disable iff (!RESET)
		ram_wr_valid && !ram_wr_ready |=> ram_wr_valid &&
		$stable(ram_wr_addr) && $stable(ram_wr_data));

endmodule

`default_nettype wire

//--- logic/memmap_pkg.sv
//==========================================================
// Memory side types for the ROM download path
// RAM byte address, boot ROM word address and the
// default placement of the handheld cartridge image
//==========================================================
`default_nettype none

package memmap_pkg;

	// RAM byte address as seen by the SDRAM write channel
	typedef logic [26:0] ram_addr_t;

	// Boot ROM word address
	// Top bit is the bank from index bit 6
	typedef logic [9:0] bootrom_addr_t;

	// Handheld image sits at 8 MiB
	localparam ram_addr_t CART_HANDHELD_BASE_DEFAULT = 27'h0800000;

endpackage

`default_nettype wire

//--- logic/rom_loader.sv
//==========================================================
// ROM download front end, top level
// Host halfword stream in; boot ROM write port, RAM write
// channel and cart status out. CART_BASE places the
// handheld image in RAM
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module rom_loader #(
	parameter memmap_pkg::ram_addr_t CART_BASE = memmap_pkg::CART_HANDHELD_BASE_DEFAULT
) (
	input  wire logic                      clk_1x,
	input  wire logic                      RESET,
	// Host download port
	input  wire logic                      ioctl_download,
	input  wire logic [7:0]                ioctl_index,
	input  wire loader_pkg::host_addr_t    ioctl_addr,
	input  wire loader_pkg::halfword_t     ioctl_dout,
	input  wire logic                      ioctl_wr,
	output      logic                      ioctl_wait,
	// Boot ROM
	output      memmap_pkg::bootrom_addr_t pifrom_wraddress,
	output      loader_pkg::word_t         pifrom_wrdata,
	output      logic                      pifrom_wren,
	// RAM write channel
	output      logic                      ram_wr_valid,
	output      memmap_pkg::ram_addr_t     ram_wr_addr,
	output      loader_pkg::word_t         ram_wr_data,
	input  wire logic                      ram_wr_ready,
	// Status
	output      logic                      cart_loaded,
	output      logic                      cart_main_download,
	output      logic                      cart_handheld_download,
	output      logic                      romcopy_start,
	output      loader_pkg::host_addr_t    romcopy_size
);

	halfword_if hw_link ();
	word_if     wd_link ();

	download_decoder download_decoder_i (
		.clk_1x                 (clk_1x),
		.RESET                  (RESET),
		.ioctl_download         (ioctl_download),
		.ioctl_wr               (ioctl_wr),
		.ioctl_index            (ioctl_index),
		.ioctl_addr             (ioctl_addr),
		.ioctl_dout             (ioctl_dout),
		.ioctl_wait             (ioctl_wait),
		.cart_loaded            (cart_loaded),
		.cart_main_download     (cart_main_download),
		.cart_handheld_download (cart_handheld_download),
		.romcopy_start          (romcopy_start),
		.romcopy_size           (romcopy_size),
		.hw                     (hw_link.src),
		.done                   (wd_link.done)
	);

	word_packer #(
		.CART_BASE (CART_BASE)
	) word_packer_i (
		.clk_1x (clk_1x),
		.RESET  (RESET),
		.hw     (hw_link.dst),
		.wd     (wd_link.src)
	);

	mem_write_port mem_write_port_i (
		.clk_1x           (clk_1x),
		.RESET            (RESET),
		.wd               (wd_link.dst),
		.pifrom_wraddress (pifrom_wraddress),
		.pifrom_wrdata    (pifrom_wrdata),
		.pifrom_wren      (pifrom_wren),
		.ram_wr_valid     (ram_wr_valid),
		.ram_wr_addr      (ram_wr_addr),
		.ram_wr_data      (ram_wr_data),
		.ram_wr_ready     (ram_wr_ready)
	);

endmodule

`default_nettype wire

//--- logic/word_if.sv
//==========================================================
// Packed words from the packer to the memory write port
// A word moves when valid and ready are both high; done
// flags a handheld word accepted by the RAM channel
//==========================================================
`timescale 1ns/1ns
`default_nettype none

interface word_if;

	logic                      valid;
	loader_pkg::dl_target_e    target;
	memmap_pkg::bootrom_addr_t rom_addr;
	memmap_pkg::ram_addr_t     ram_addr;
	loader_pkg::word_t         data;
	logic                      ready;
	logic                      done;

	modport src (output valid, output target, output rom_addr, output ram_addr,
		output data, input ready, input done);
	modport dst (input valid, input target, input rom_addr, input ram_addr,
		input data, output ready, output done);

endinterface

`default_nettype wire

//--- logic/word_packer.sv
//==========================================================
// Packs pairs of halfwords into 32-bit words
// Boot ROM words are byte swapped, lower half on top
// Handheld words keep host order and are placed at
// the host address plus CART_BASE in RAM
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module word_packer #(
	parameter memmap_pkg::ram_addr_t CART_BASE = memmap_pkg::CART_HANDHELD_BASE_DEFAULT
) (
	input wire logic clk_1x,
	input wire logic RESET,
	halfword_if.dst  hw,
	word_if.src      wd
);

	loader_pkg::halfword_t  pend_half;
	loader_pkg::host_addr_t pend_addr;
	logic                   pend_bank;
	logic                   out_free;
	logic                   load_word;

	function automatic loader_pkg::halfword_t byte_swap(input loader_pkg::halfword_t h);
		return {h[7:0], h[15:8]};
	endfunction

	assign out_free  = !wd.valid || wd.ready;
	// Upper half completes the word
	assign load_word = hw.valid && hw.addr[1] && out_free;

	always_ff @(posedge clk_1x) begin
		if (!RESET)
			wd.valid <= 1'b0;
		else if (load_word)
			wd.valid <= 1'b1;
		else if (wd.ready)
			wd.valid <= 1'b0;
	end

	// Lower half parks here, address and bank come from it
	always_ff @(posedge clk_1x) begin
		if (hw.valid && !hw.addr[1]) begin
			pend_half <= hw.data;
			pend_addr <= hw.addr;
			pend_bank <= hw.bank;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (load_word) begin
			wd.target   <= hw.target;
			wd.rom_addr <= {pend_bank, pend_addr[10:2]};
			wd.ram_addr <= memmap_pkg::ram_addr_t'(pend_addr) + CART_BASE;
			if (hw.target == loader_pkg::CART_HANDHELD)
				wd.data <= {hw.data, pend_half};
			else
				wd.data <= {byte_swap(pend_half), byte_swap(hw.data)};
		end
	end

	// Word must not move or change while the port stalls
	word_hold_a: assert property (@(posedge clk_1x) disable iff (!RESET)
		wd.valid && !wd.ready |=> wd.valid && $stable(wd.data) &&
		$stable(wd.ram_addr) && $stable(wd.target));

endmodule

`default_nettype wire

//--- sim/rom_loader_tb.sv
//==========================================================
// Testbench for the ROM download front end
// Random host downloads to boot ROM, main and handheld cart
// with random RAM back-pressure; a model predicts every
// boot ROM write, RAM write, host stall and copy start
//==========================================================
`timescale 1ns/1ns
`default_nettype none

module rom_loader_tb;

	localparam memmap_pkg::ram_addr_t CART_BASE = 27'h1200000;
	localparam int NUM_DL       = 14;
	localparam int MAX_WORDS    = 16;
	localparam int READY_PCT    = 60;
	localparam int STALL_MARGIN = 40;
	// 4 cycles per halfword plus a stall allowance per word
	localparam int MAX_CYCLES   = 4 * NUM_DL * MAX_WORDS * 2 +
		NUM_DL * MAX_WORDS * STALL_MARGIN + 200;

	logic                      clk_1x;
	logic                      RESET;
	logic                      ioctl_download;
	logic [7:0]                ioctl_index;
	loader_pkg::host_addr_t    ioctl_addr;
	loader_pkg::halfword_t     ioctl_dout;
	logic                      ioctl_wr;
	logic                      ioctl_wait;
	memmap_pkg::bootrom_addr_t pifrom_wraddress;
	loader_pkg::word_t         pifrom_wrdata;
	logic                      pifrom_wren;
	logic                      ram_wr_valid;
	memmap_pkg::ram_addr_t     ram_wr_addr;
	loader_pkg::word_t         ram_wr_data;
	logic                      ram_wr_ready;
	logic                      cart_loaded;
	logic                      cart_main_download;
	logic                      cart_handheld_download;
	logic                      romcopy_start;
	loader_pkg::host_addr_t    romcopy_size;

	integer                 seed;
	int                     cycles;
	int                     main_count;
	int                     copy_count;
	logic                   wait_exp;
	logic                   hs_pending;
	logic                   copy_exp;
	logic                   main_done;
	loader_pkg::host_addr_t copy_size_exp;

	// Expected writes, oldest first
	logic [9:0]  exp_rom_addr[$];
	logic [31:0] exp_rom_data[$];
	int          exp_rom_cycle[$];
	logic [26:0] exp_ram_addr[$];
	logic [31:0] exp_ram_data[$];

	rom_loader #(
		.CART_BASE (CART_BASE)
	) rom_loader_i (
		.clk_1x                 (clk_1x),
		.RESET                  (RESET),
		.ioctl_download         (ioctl_download),
		.ioctl_index            (ioctl_index),
		.ioctl_addr             (ioctl_addr),
		.ioctl_dout             (ioctl_dout),
		.ioctl_wr               (ioctl_wr),
		.ioctl_wait             (ioctl_wait),
		.pifrom_wraddress       (pifrom_wraddress),
		.pifrom_wrdata          (pifrom_wrdata),
		.pifrom_wren            (pifrom_wren),
		.ram_wr_valid           (ram_wr_valid),
		.ram_wr_addr            (ram_wr_addr),
		.ram_wr_data            (ram_wr_data),
		.ram_wr_ready           (ram_wr_ready),
		.cart_loaded            (cart_loaded),
		.cart_main_download     (cart_main_download),
		.cart_handheld_download (cart_handheld_download),
		.romcopy_start          (romcopy_start),
		.romcopy_size           (romcopy_size)
	);

	initial begin
		clk_1x = 1'b0;
		forever #2 clk_1x = ~clk_1x;
	end

	always @(posedge clk_1x) begin
		cycles <= cycles + 1;
		if (cycles > MAX_CYCLES)
			report_fault("run did not finish within the cycle limit");
	end

	//==========================================================
	// Error reporting
	//==========================================================
	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
		abort_run();
	endtask

	task automatic report_fault(input string what);
		$display("Error: %s", what);
		abort_run();
	endtask

	//==========================================================
	// One falling edge: update the model, check, drive ready
	//==========================================================
	task automatic step_cycle();
		logic exp_main;
		logic exp_hh;
		@(negedge clk_1x);
		exp_main = ioctl_download && ioctl_index[5:0] == 6'd1;
		exp_hh   = ioctl_download && ioctl_index[5:0] == 6'd2;
		// Upper handheld half raises the stall, handshake drops it
		if (exp_hh && ioctl_wr && ioctl_addr[1])
			wait_exp = 1'b1;
		if (hs_pending)
			wait_exp = 1'b0;
		hs_pending = 1'b0;
		assert (ioctl_wait == wait_exp)
			else report_mismatch("host stall", wait_exp, ioctl_wait);
		assert (cart_main_download == exp_main)
			else report_mismatch("main flag", exp_main, cart_main_download);
		assert (cart_handheld_download == exp_hh)
			else report_mismatch("handheld flag", exp_hh, cart_handheld_download);
		assert (romcopy_start == copy_exp)
			else report_mismatch("copy start", copy_exp, romcopy_start);
		if (copy_exp) begin
			assert (romcopy_size == copy_size_exp)
				else report_mismatch("copy size", copy_size_exp, romcopy_size);
		end
		// Pulses actually seen on the port
		if (romcopy_start)
			copy_count++;
		copy_exp = 1'b0;
		if (main_done)
			assert (cart_loaded) else report_fault("cart_loaded fell after a main download");
		if (main_count == 0)
			assert (!cart_loaded) else report_fault("cart_loaded high before any main download");

		if (pifrom_wren) begin
			assert (exp_rom_cycle.size() != 0)
				else report_fault("boot ROM write with no word expected");
			assert (cycles == exp_rom_cycle[0])
				else report_mismatch("boot ROM latency", exp_rom_cycle[0], cycles);
			assert (pifrom_wraddress == exp_rom_addr[0])
				else report_mismatch("boot ROM address", exp_rom_addr[0], pifrom_wraddress);
			assert (pifrom_wrdata == exp_rom_data[0])
				else report_mismatch("boot ROM data", exp_rom_data[0], pifrom_wrdata);
			void'(exp_rom_cycle.pop_front());
			void'(exp_rom_addr.pop_front());
			void'(exp_rom_data.pop_front());
		end
		assert (exp_rom_cycle.size() == 0 || exp_rom_cycle[0] > cycles)
			else report_fault("boot ROM write missing at its expected cycle");

		// New ready, the handshake happens at the next rising edge
		ram_wr_ready = ({$random(seed)} % 100) < READY_PCT;
		if (ram_wr_valid && ram_wr_ready) begin
			assert (exp_ram_addr.size() != 0)
				else report_fault("RAM write with no word expected");
			assert (ram_wr_addr == exp_ram_addr[0])
				else report_mismatch("RAM address", exp_ram_addr[0], ram_wr_addr);
			assert (ram_wr_data == exp_ram_data[0])
				else report_mismatch("RAM data", exp_ram_data[0], ram_wr_data);
			void'(exp_ram_addr.pop_front());
			void'(exp_ram_data.pop_front());
			hs_pending = 1'b1;
		end
	endtask

	//==========================================================
	// Host model
	//==========================================================
	task automatic host_write(input loader_pkg::host_addr_t a, input loader_pkg::halfword_t d);
		step_cycle();
		while (ioctl_wait) begin
			ioctl_wr = 1'b0;
			step_cycle();
		end
		ioctl_wr   = 1'b1;
		ioctl_addr = a;
		ioctl_dout = d;
	endtask

	task automatic idle_gap();
		int n;
		n = {$random(seed)} % 3;
		repeat (n) begin
			step_cycle();
			ioctl_wr = 1'b0;
		end
	endtask

	task automatic start_download(input logic [7:0] idx);
		step_cycle();
		ioctl_wr       = 1'b0;
		ioctl_download = 1'b1;
		ioctl_index    = idx;
		if (idx[5:0] == 6'd1)
			main_count++;
	endtask

	// Index and address stay put so the drop is seen with them
	task automatic end_download();
		step_cycle();
		ioctl_wr       = 1'b0;
		ioctl_download = 1'b0;
		if (ioctl_index[5:0] == 6'd1) begin
			copy_exp      = 1'b1;
			copy_size_exp = ioctl_addr;
			main_done     = 1'b1;
		end
	endtask

	initial begin
		int                     kind;
		int                     nwords;
		logic [7:0]             idx;
		loader_pkg::host_addr_t base;
		loader_pkg::host_addr_t a;
		loader_pkg::halfword_t  lo;
		loader_pkg::halfword_t  hi;
		seed           = 32'hd5212f43;
		cycles         = 0;
		main_count     = 0;
		copy_count     = 0;
		wait_exp       = 1'b0;
		hs_pending     = 1'b0;
		copy_exp       = 1'b0;
		main_done      = 1'b0;
		copy_size_exp  = '0;
		RESET          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		ram_wr_ready   = 1'b0;
		repeat (8) @(negedge clk_1x);
		assert (!pifrom_wren && !ram_wr_valid && !ioctl_wait && !romcopy_start &&
			!cart_loaded && !cart_main_download && !cart_handheld_download)
			else report_fault("control outputs not low in reset");
		RESET = 1'b1;

		for (int d = 0; d < NUM_DL; d++) begin
			kind   = {$random(seed)} % 3;
			idx    = 8'(kind);
			idx[6] = $random(seed);
			nwords = 1 + {$random(seed)} % MAX_WORDS;
			base   = 27'(({$random(seed)} % 512) * 4);
			start_download(idx);
			for (int w = 0; w < nwords; w++) begin
				a  = base + 27'(4 * w);
				lo = $random(seed);
				hi = $random(seed);
				host_write(a, lo);
				idle_gap();
				host_write(a + 27'd2, hi);
				if (kind == 0) begin
					exp_rom_addr.push_back({idx[6], a[10:2]});
					exp_rom_data.push_back({lo[7:0], lo[15:8], hi[7:0], hi[15:8]});
					exp_rom_cycle.push_back(cycles + 3);
				end else if (kind == 2) begin
					exp_ram_addr.push_back(a + CART_BASE);
					exp_ram_data.push_back({hi, lo});
				end
				idle_gap();
			end
			end_download();
		end

		// Let the last words and the copy pulse come out
		while (exp_rom_cycle.size() != 0 || exp_ram_addr.size() != 0 ||
			ioctl_wait || copy_exp) begin
			step_cycle();
		end
		repeat (6) step_cycle();

		assert (cart_loaded == (main_count != 0))
			else report_mismatch("cart loaded", main_count != 0, cart_loaded);
		assert (copy_count == main_count)
			else report_mismatch("copy start count", main_count, copy_count);
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
logic/loader_pkg.sv
logic/memmap_pkg.sv
logic/halfword_if.sv
logic/word_if.sv
logic/download_decoder.sv
logic/word_packer.sv
logic/mem_write_port.sv
logic/rom_loader.sv
sim/rom_loader_tb.sv
